// File: logic/img_pkg.sv
package img_pkg;

	// --------------------------------------------------------------------
	// image geometry
	// --------------------------------------------------------------------
	localparam int IMG_DIM    = 8;   // width and height
	localparam int MAX_DEPTH  = 32;  // stored channels
	localparam int MIN_DEPTH  = 8;
	localparam int ORIGIN_MAX = 6;   // window origin stays in 0..6

	localparam int PIX_W  = 8;
	localparam int ADDR_W = 11;      // 32 ch * 64 pixels
	localparam int OUT_W  = 14;
	localparam int ACC_W  = 17;      // 16 * 255 * 32 still fits

	// --------------------------------------------------------------------
	// op codes, 9 and 10 reserved
	// --------------------------------------------------------------------
	typedef enum logic [3:0] {
		LOAD           = 4'd0,
		RIGHT          = 4'd1,
		LEFT           = 4'd2,
		UP             = 4'd3,
		DOWN           = 4'd4,
		REDUCE_DEPTH   = 4'd5,
		INCREASE_DEPTH = 4'd6,
		DISPLAY        = 4'd7,
		CONV           = 4'd8
	} op_mode_e;

	typedef logic [2:0]        coord_t;
	typedef logic [5:0]        depth_t;
	typedef logic [PIX_W-1:0]  pixel_t;
	typedef logic [ADDR_W-1:0] addr_t;  // c*64 + y*8 + x
	typedef logic [OUT_W-1:0]  out_data_t;
	typedef logic [ACC_W-1:0]  acc_t;

	typedef enum logic {
		SCAN_DISPLAY = 1'b0,
		SCAN_CONV    = 1'b1
	} scan_mode_e;

endpackage

// File: logic/pixel_mem.sv
`timescale 1ns/100ps

module pixel_mem #(
	parameter int DATA_W = 8,
	parameter int ADDR_W = 11
) (
	input  logic              i_clk,
	input  logic              i_wr_en,
	input  logic              i_rd_en,
	input  logic [ADDR_W-1:0] i_addr,
	input  logic [DATA_W-1:0] i_wr_data,
	output logic [DATA_W-1:0] o_rd_data
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// single port, write wins over read
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[i_addr] <= i_wr_data;
		end else if (i_rd_en) begin
			o_rd_data <= mem[i_addr];  // data valid one cycle after enable
		end
	end

endmodule

// File: logic/img_ctrl.sv
`timescale 1ns/100ps

module img_ctrl (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_op_valid,
	input  img_pkg::op_mode_e    i_op_mode,
	input  logic                 i_in_valid,
	input  img_pkg::pixel_t      i_in_data,
	input  logic                 i_scan_done,
	input  logic                 i_filter_done,
	output logic                 o_op_ready,
	output logic                 o_in_ready,
	output logic                 o_loading,
	output logic                 o_wr_en,
	output img_pkg::addr_t       o_wr_addr,
	output img_pkg::pixel_t      o_wr_data,
	output logic                 o_scan_start,
	output img_pkg::scan_mode_e  o_scan_mode,
	output img_pkg::coord_t      o_origin_x,
	output img_pkg::coord_t      o_origin_y,
	output img_pkg::depth_t      o_depth
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_STEP,   // one cycle for move / depth ops and load wrap-up
		ST_SCAN,
		ST_DRAIN   // scan finished, filter still emitting
	} state_e;

	state_e            state;
	img_pkg::op_mode_e op_q;
	img_pkg::addr_t    load_cnt;
	logic              op_accept;
	img_pkg::coord_t   xy_max;
	img_pkg::depth_t   depth_min;
	img_pkg::depth_t   depth_max;

	assign op_accept = o_op_ready && i_op_valid;
	assign xy_max    = img_pkg::coord_t'(img_pkg::ORIGIN_MAX);
	assign depth_min = img_pkg::depth_t'(img_pkg::MIN_DEPTH);
	assign depth_max = img_pkg::depth_t'(img_pkg::MAX_DEPTH);

	// load path straight to the memory
	assign o_loading = (state == ST_LOAD);
	assign o_wr_en   = o_in_ready && i_in_valid;
	assign o_wr_addr = load_cnt;
	assign o_wr_data = i_in_data;

	// --------------------------------------------------------------------
	// op FSM
	// --------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state        <= ST_IDLE;
			op_q         <= img_pkg::LOAD;
			o_op_ready   <= 1'b0;
			o_in_ready   <= 1'b0;
			o_scan_start <= 1'b0;
			o_scan_mode  <= img_pkg::SCAN_DISPLAY;
			load_cnt     <= '0;
			o_origin_x   <= '0;
			o_origin_y   <= '0;
			o_depth      <= depth_max;
		end else begin
			o_scan_start <= 1'b0;  // single-cycle pulse
			case (state)
				ST_IDLE: begin
					if (op_accept) begin
						o_op_ready <= 1'b0;
						op_q       <= i_op_mode;
						case (i_op_mode)
							img_pkg::LOAD: begin
								state      <= ST_LOAD;
								o_in_ready <= 1'b1;
								load_cnt   <= '0;
							end
							img_pkg::DISPLAY, img_pkg::CONV: begin
								state        <= ST_SCAN;
								o_scan_start <= 1'b1;
								o_scan_mode  <= (i_op_mode == img_pkg::CONV) ?
									img_pkg::SCAN_CONV : img_pkg::SCAN_DISPLAY;
							end
							default: state <= ST_STEP;  // reserved codes fall through too
						endcase
					end else begin
						o_op_ready <= 1'b1;
					end
				end
				ST_LOAD: begin
					if (o_wr_en) begin
						load_cnt <= load_cnt + 1'b1;
						if (load_cnt == '1) begin  // 2048th byte
							o_in_ready <= 1'b0;
							state      <= ST_STEP;
						end
					end
				end
				ST_STEP: begin
					case (op_q)
						img_pkg::RIGHT: if (o_origin_x != xy_max) o_origin_x <= o_origin_x + 3'd1;
						img_pkg::LEFT:  if (o_origin_x != '0) o_origin_x <= o_origin_x - 3'd1;
						img_pkg::UP:    if (o_origin_y != '0) o_origin_y <= o_origin_y - 3'd1;
						img_pkg::DOWN:  if (o_origin_y != xy_max) o_origin_y <= o_origin_y + 3'd1;
						img_pkg::REDUCE_DEPTH: begin
							if (o_depth != depth_min)
								o_depth <= o_depth >> 1;
						end
						img_pkg::INCREASE_DEPTH: begin
							if (o_depth != depth_max)
								o_depth <= o_depth << 1;
						end
						default: ;
					endcase
					o_op_ready <= 1'b1;
					state      <= ST_IDLE;
				end
				ST_SCAN: begin
					if (i_scan_done)
						state <= ST_DRAIN;
				end
				ST_DRAIN: begin
					// ready comes back right after the last output
					if (i_filter_done) begin
						o_op_ready <= 1'b1;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: logic/window_scan.sv
`timescale 1ns/100ps

module window_scan (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_start,
	input  img_pkg::scan_mode_e i_mode,
	input  img_pkg::coord_t     i_origin_x,
	input  img_pkg::coord_t     i_origin_y,
	input  img_pkg::depth_t     i_depth,
	output logic                o_rd_en,
	output img_pkg::addr_t      o_rd_addr,
	output logic                o_in_image,
	output logic [1:0]          o_rel_row,
	output logic [1:0]          o_rel_col,
	output logic                o_last,
	output logic                o_done
);

	logic       active_q;
	logic [4:0] chan_q;
	logic [1:0] row_q;
	logic [1:0] col_q;
	logic       is_conv;
	logic [1:0] span;    // last row / col index of the walk
	logic [3:0] ax;      // one spare bit catches -1 and 8
	logic [3:0] ay;
	logic       col_end;
	logic       row_end;
	logic       chan_end;
	logic       pos_last;

	assign is_conv = (i_mode == img_pkg::SCAN_CONV);
	assign span    = is_conv ? 2'd3 : 2'd1;

	// conv walks origin-1 .. origin+2, display origin .. origin+1
	assign ax = {1'b0, i_origin_x} + {2'b00, col_q} - {3'b000, is_conv};
	assign ay = {1'b0, i_origin_y} + {2'b00, row_q} - {3'b000, is_conv};

	assign o_in_image = (ax < 4'(img_pkg::IMG_DIM)) && (ay < 4'(img_pkg::IMG_DIM));
	assign o_rd_en    = active_q && o_in_image;
	assign o_rd_addr  = {chan_q, ay[2:0], ax[2:0]};
	assign o_rel_row  = row_q;
	assign o_rel_col  = col_q;

	assign col_end  = (col_q == span);
	assign row_end  = (row_q == span);
	assign chan_end = ({1'b0, chan_q} == i_depth - 6'd1);
	assign pos_last = col_end && row_end && chan_end;
	assign o_last   = active_q && pos_last;

	// --------------------------------------------------------------------
	// position counters, col fastest then row then channel
	// --------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active_q <= 1'b0;
			chan_q   <= '0;
			row_q    <= '0;
			col_q    <= '0;
			o_done   <= 1'b0;
		end else begin
			o_done <= o_last;  // pulse after final read issued
			if (i_start) begin
				active_q <= 1'b1;
				chan_q   <= '0;
				row_q    <= '0;
				col_q    <= '0;
			end else if (active_q) begin
				col_q <= col_end ? 2'd0 : col_q + 2'd1;
				if (col_end) begin
					row_q <= row_end ? 2'd0 : row_q + 2'd1;
					if (row_end) begin
						chan_q <= chan_end ? 5'd0 : chan_q + 5'd1;
						if (chan_end)
							active_q <= 1'b0;
					end
				end
			end
		end
	end

endmodule

// File: logic/filter_unit.sv
`timescale 1ns/100ps

module filter_unit (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  img_pkg::scan_mode_e i_mode,
	input  logic                i_valid,
	input  logic                i_in_image,
	input  logic [1:0]          i_rel_row,
	input  logic [1:0]          i_rel_col,
	input  logic                i_last,
	input  img_pkg::pixel_t     i_rd_data,
	output logic                o_out_valid,
	output img_pkg::out_data_t  o_out_data,
	output logic                o_done
);

	logic            valid_d;
	logic            last_d;
	logic            in_image_d;
	logic [1:0]      row_d;
	logic [1:0]      col_d;
	logic            conv_mode;
	logic            start_drain;
	logic            draining;
	logic [1:0]      drain_idx;
	logic [1:0]      out_sel;
	img_pkg::pixel_t pix;
	img_pkg::acc_t   sum_q   [4];
	img_pkg::acc_t   sum_nxt [4];
	img_pkg::acc_t   rnd;

	// gaussian tap of position (row, col) for the result centred at (wy+1, wx+1)
	function automatic img_pkg::acc_t tap(input logic [1:0] row, input logic [1:0] col,
			input int wy, input int wx, input img_pkg::pixel_t p);
		int dr;
		int dc;
		int sh;
		img_pkg::acc_t w;
		dr = int'(row) - wy;
		dc = int'(col) - wx;
		sh = 0;
		if (dr == 1)
			sh++;
		if (dc == 1)
			sh++;
		if (dr < 0 || dr > 2 || dc < 0 || dc > 2)
			w = '0;
		else
			w = img_pkg::acc_t'(p) << sh;  // weights 1 / 2 / 4
		return w;
	endfunction

	// --------------------------------------------------------------------
	// line scan flags up with the memory output
	// --------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_d <= 1'b0;
			last_d  <= 1'b0;
		end else begin
			valid_d <= i_valid;
			last_d  <= i_last;
		end
	end

	always_ff @(posedge i_clk) begin
		in_image_d <= i_in_image;
		row_d      <= i_rel_row;
		col_d      <= i_rel_col;
	end

	assign conv_mode   = (i_mode == img_pkg::SCAN_CONV);
	assign pix         = in_image_d ? i_rd_data : '0;  // zero padding
	assign start_drain = last_d && conv_mode;

	always_comb begin
		for (int j = 0; j < 4; j++) begin
			sum_nxt[j] = sum_q[j];
			if (valid_d && conv_mode)
				sum_nxt[j] = sum_q[j] + tap(row_d, col_d, j / 2, j % 2, pix);
		end
	end

	// result 0 leaves together with the last accumulate
	assign out_sel = start_drain ? 2'd0 : drain_idx;
	assign rnd     = sum_nxt[out_sel] + img_pkg::acc_t'(8);

	// --------------------------------------------------------------------
	// output and drain control
	// --------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
			o_done      <= 1'b0;
			draining    <= 1'b0;
			drain_idx   <= '0;
			for (int j = 0; j < 4; j++)
				sum_q[j] <= '0;
		end else begin
			o_out_valid <= valid_d && !conv_mode;  // display pixel
			o_done      <= valid_d && !conv_mode && last_d;
			for (int j = 0; j < 4; j++)
				sum_q[j] <= sum_nxt[j];
			if (start_drain) begin
				o_out_valid <= 1'b1;
				draining    <= 1'b1;
				drain_idx   <= 2'd1;
			end else if (draining) begin
				o_out_valid <= 1'b1;
				drain_idx   <= drain_idx + 2'd1;
				if (drain_idx == 2'd3) begin
					draining <= 1'b0;
					o_done   <= 1'b1;
					for (int j = 0; j < 4; j++)
						sum_q[j] <= '0;  // ready for next conv
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (conv_mode)
			o_out_data <= img_pkg::out_data_t'(rnd[img_pkg::ACC_W-1:4]);  // (sum+8)>>4
		else
			o_out_data <= img_pkg::out_data_t'(i_rd_data);
	end

endmodule

// File: logic/img_core.sv
`timescale 1ns/100ps

module img_core (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_op_valid,
	input  img_pkg::op_mode_e  i_op_mode,
	output logic               o_op_ready,
	input  logic               i_in_valid,
	input  img_pkg::pixel_t    i_in_data,
	output logic               o_in_ready,
	output logic               o_out_valid,
	output img_pkg::out_data_t o_out_data
);

	logic                loading;
	logic                wr_en;
	img_pkg::addr_t      wr_addr;
	img_pkg::pixel_t     wr_data;
	logic                scan_start;
	img_pkg::scan_mode_e scan_mode;
	img_pkg::coord_t     origin_x;
	img_pkg::coord_t     origin_y;
	img_pkg::depth_t     depth;
	logic                scan_done;
	logic                filter_done;

	logic                rd_en;
	img_pkg::addr_t      rd_addr;
	logic                in_image;
	logic [1:0]          rel_row;
	logic [1:0]          rel_col;
	logic                scan_last;

	logic                mem_rd_en;
	img_pkg::addr_t      mem_addr;
	img_pkg::pixel_t     rd_data;

	img_ctrl u_ctrl (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_op_valid    (i_op_valid),
		.i_op_mode     (i_op_mode),
		.i_in_valid    (i_in_valid),
		.i_in_data     (i_in_data),
		.i_scan_done   (scan_done),
		.i_filter_done (filter_done),
		.o_op_ready    (o_op_ready),
		.o_in_ready    (o_in_ready),
		.o_loading     (loading),
		.o_wr_en       (wr_en),
		.o_wr_addr     (wr_addr),
		.o_wr_data     (wr_data),
		.o_scan_start  (scan_start),
		.o_scan_mode   (scan_mode),
		.o_origin_x    (origin_x),
		.o_origin_y    (origin_y),
		.o_depth       (depth)
	);

	window_scan u_scan (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (scan_start),
		.i_mode     (scan_mode),
		.i_origin_x (origin_x),
		.i_origin_y (origin_y),
		.i_depth    (depth),
		.o_rd_en    (rd_en),
		.o_rd_addr  (rd_addr),
		.o_in_image (in_image),
		.o_rel_row  (rel_row),
		.o_rel_col  (rel_col),
		.o_last     (scan_last),
		.o_done     (scan_done)
	);

	// load owns the port, scans read otherwise
	assign mem_addr  = loading ? wr_addr : rd_addr;
	assign mem_rd_en = !loading && rd_en;

	pixel_mem #(
		.DATA_W (img_pkg::PIX_W),
		.ADDR_W (img_pkg::ADDR_W)
	) u_mem (
		.i_clk     (i_clk),
		.i_wr_en   (wr_en),
		.i_rd_en   (mem_rd_en),
		.i_addr    (mem_addr),
		.i_wr_data (wr_data),
		.o_rd_data (rd_data)
	);

	filter_unit u_filter (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_mode      (scan_mode),
		.i_valid     (rd_en),      // one per issued read
		.i_in_image  (in_image),
		.i_rel_row   (rel_row),
		.i_rel_col   (rel_col),
		.i_last      (scan_last),
		.i_rd_data   (rd_data),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_done      (filter_done)
	);

endmodule

// File: sim/img_core_asserts.sv
`timescale 1ns/100ps

module img_core_asserts (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_op_ready,
	input logic i_in_ready,
	input logic i_out_valid,
	input logic i_loading
);

	// --------------------------------------------------------------------
	// top-level handshake rules
	// --------------------------------------------------------------------
	ready_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_op_ready && i_in_ready))
		else $error("o_op_ready and o_in_ready high in the same cycle");

	no_output_when_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_op_ready |-> !i_out_valid)
		else $error("o_out_valid high while o_op_ready is high");

	in_ready_only_in_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_in_ready |-> i_loading)
		else $error("o_in_ready high outside a load");

	// all control outputs quiet while held in reset
	reset_quiet: assert property (@(posedge i_clk)
		!i_rst_n |-> (!i_op_ready && !i_in_ready && !i_out_valid))
		else $error("control output high during reset");

endmodule

// File: sim/tb_img_core.sv
`timescale 1ns/100ps

module tb_img_core;

	localparam int N_PIX       = img_pkg::MAX_DEPTH * img_pkg::IMG_DIM * img_pkg::IMG_DIM;
	localparam int N_RANDOM    = 40;
	localparam int CYCLE_LIMIT = 2 * (N_PIX + N_RANDOM * (16 * img_pkg::MAX_DEPTH + 8) + 100);

	logic               i_clk;
	logic               i_rst_n;
	logic               i_op_valid;
	img_pkg::op_mode_e  i_op_mode;
	logic               o_op_ready;
	logic               i_in_valid;
	img_pkg::pixel_t    i_in_data;
	logic               o_in_ready;
	logic               o_out_valid;
	img_pkg::out_data_t o_out_data;

	// reference model state
	img_pkg::pixel_t    img [N_PIX];
	int                 org_x;
	int                 org_y;
	int                 depth;

	logic [31:0]        lcg_state;
	int                 cycles = 0;
	int                 errors;
	int                 checks;
	int                 tests_run;
	int                 tests_bad;
	int                 test_err0;
	string              test_name;
	logic               out_allowed;   // a display or conv is running
	img_pkg::out_data_t out_q [$];
	img_pkg::out_data_t exp_q [$];

	initial i_clk = 1'b0;
	always #4 i_clk = ~i_clk;

	img_core uut (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.o_op_ready  (o_op_ready),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	bind img_core img_core_asserts u_asserts (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_ready  (o_op_ready),
		.i_in_ready  (o_in_ready),
		.i_out_valid (o_out_valid),
		.i_loading   (loading)
	);

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {17'd0, lcg_state[30:16]};
	endfunction

	// --------------------------------------------------------------------
	// run limit and output capture
	// --------------------------------------------------------------------
	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("tests failed");
			$finish;
		end
	end

	always @(negedge i_clk) begin
		if (i_rst_n && o_out_valid) begin
			if (out_allowed) begin
				out_q.push_back(o_out_data);
			end else begin
				$display("output appeared at %0t with no display or conv running", $time);
				errors++;
			end
		end
	end

	task automatic check_display_pixel(input img_pkg::out_data_t exp,
			input img_pkg::out_data_t act);
		checks++;
		if (act !== exp) begin
			$display("ERR t=%0t o_out_data display exp=%0d got=%0d", $time, exp, act);
			errors++;
		end
	endtask

	task automatic check_conv_result(input img_pkg::out_data_t exp,
			input img_pkg::out_data_t act);
		checks++;
		if (act !== exp) begin
			$display("ERR t=%0t o_out_data conv exp=%0d got=%0d", $time, exp, act);
			errors++;
		end
	endtask

	// zero outside the image
	function automatic int pix_at(input int c, input int y, input int x);
		if (x < 0 || x >= img_pkg::IMG_DIM || y < 0 || y >= img_pkg::IMG_DIM)
			return 0;
		return int'(img[c * 64 + y * 8 + x]);
	endfunction

	task automatic build_display_expect();
		exp_q.delete();
		for (int c = 0; c < depth; c++)
			for (int y = org_y; y <= org_y + 1; y++)
				for (int x = org_x; x <= org_x + 1; x++)
					exp_q.push_back(img_pkg::out_data_t'(pix_at(c, y, x)));
	endtask

	task automatic build_conv_expect();
		int sum;
		int cy;
		int cx;
		exp_q.delete();
		for (int j = 0; j < 4; j++) begin
			cy  = org_y + j / 2;  // centre of result j
			cx  = org_x + j % 2;
			sum = 0;
			for (int c = 0; c < depth; c++)
				for (int dy = -1; dy <= 1; dy++)
					for (int dx = -1; dx <= 1; dx++)
						sum += (dy == 0 ? 2 : 1) * (dx == 0 ? 2 : 1) *
							pix_at(c, cy + dy, cx + dx);
			exp_q.push_back(img_pkg::out_data_t'((sum + 8) >> 4));
		end
	endtask

	// --------------------------------------------------------------------
	// op handshake
	// --------------------------------------------------------------------
	task automatic wait_ready();
		do @(negedge i_clk); while (o_op_ready !== 1'b1);
	endtask

	// returns on the edge that accepts the op
	task automatic issue_op(input img_pkg::op_mode_e mode);
		wait_ready();
		@(posedge i_clk);
		i_op_valid <= 1'b1;
		i_op_mode  <= mode;
		@(posedge i_clk);
		i_op_valid <= 1'b0;
	endtask

	task automatic run_op(input img_pkg::op_mode_e mode);
		logic scan;
		scan = (mode == img_pkg::DISPLAY) || (mode == img_pkg::CONV);
		out_q.delete();
		if (mode == img_pkg::DISPLAY)
			build_display_expect();
		else if (mode == img_pkg::CONV)
			build_conv_expect();
		out_allowed = scan;
		issue_op(mode);
		if (scan) begin
			wait_ready();
			out_allowed = 1'b0;
			if (out_q.size() != exp_q.size()) begin
				$display("%s gave %0d outputs instead of %0d", mode.name(),
					out_q.size(), exp_q.size());
				errors++;
			end else begin
				for (int i = 0; i < exp_q.size(); i++) begin
					if (mode == img_pkg::DISPLAY)
						check_display_pixel(exp_q[i], out_q[i]);
					else
						check_conv_result(exp_q[i], out_q[i]);
				end
			end
		end else begin
			@(negedge i_clk);
			@(negedge i_clk);
			if (o_op_ready !== 1'b1) begin
				$display("o_op_ready not back two cycles after %s", mode.name());
				errors++;
			end
			case (mode)  // same clamping as the core
				img_pkg::RIGHT:          if (org_x < img_pkg::ORIGIN_MAX) org_x++;
				img_pkg::LEFT:           if (org_x > 0) org_x--;
				img_pkg::UP:             if (org_y > 0) org_y--;
				img_pkg::DOWN:           if (org_y < img_pkg::ORIGIN_MAX) org_y++;
				img_pkg::REDUCE_DEPTH:   if (depth > img_pkg::MIN_DEPTH) depth = depth / 2;
				img_pkg::INCREASE_DEPTH: if (depth < img_pkg::MAX_DEPTH) depth = depth * 2;
				default: ;
			endcase
		end
	endtask

	task automatic repeat_op(input img_pkg::op_mode_e mode, input int n);
		for (int i = 0; i < n; i++)
			run_op(mode);
	endtask

	task automatic load_image();
		int   idx;
		logic rdy;
		logic vld;
		idx = 0;
		issue_op(img_pkg::LOAD);
		vld = (lcg_next() % 4) != 0;  // random gaps
		i_in_valid <= vld;
		i_in_data  <= img[0];
		while (idx < N_PIX) begin
			@(negedge i_clk);
			rdy = o_in_ready;
			@(posedge i_clk);
			if (rdy && vld)
				idx++;
			vld = (idx < N_PIX) && ((lcg_next() % 4) != 0);
			i_in_valid <= vld;
			if (idx < N_PIX)
				i_in_data <= img[idx];
		end
		// one extra byte offered, must be refused
		i_in_valid <= 1'b1;
		i_in_data  <= 8'hff;
		@(negedge i_clk);
		if (o_in_ready !== 1'b0) begin
			$display("o_in_ready still high after %0d bytes", N_PIX);
			errors++;
		end
		@(negedge i_clk);
		if (o_op_ready !== 1'b1) begin
			$display("o_op_ready did not return one cycle after the load");
			errors++;
		end
		@(posedge i_clk);
		i_in_valid <= 1'b0;
	endtask

	task automatic run_random_mix(input int n);
		logic [3:0]        code;
		img_pkg::op_mode_e op;
		for (int i = 0; i < n; i++) begin
			code = 4'(1 + lcg_next() % 8);  // codes 1..8
			op   = img_pkg::op_mode_e'(code);
			run_op(op);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = errors;
		tests_run++;
	endtask

	task automatic report_test();
		if (errors == test_err0) begin
			$display("test %0d %s: ok", tests_run, test_name);
		end else begin
			$display("test %0d %s: FAIL, %0d errors", tests_run, test_name, errors - test_err0);
			tests_bad++;
		end
	endtask

	// --------------------------------------------------------------------
	// test sequence
	// --------------------------------------------------------------------
	initial begin
		i_rst_n     = 1'b0;
		i_op_valid  = 1'b0;
		i_op_mode   = img_pkg::LOAD;
		i_in_valid  = 1'b0;
		i_in_data   = '0;
		lcg_state   = 32'd70;
		errors      = 0;
		checks      = 0;
		tests_run   = 0;
		tests_bad   = 0;
		out_allowed = 1'b0;
		org_x       = 0;
		org_y       = 0;
		depth       = img_pkg::MAX_DEPTH;
		for (int i = 0; i < N_PIX; i++)
			img[i] = img_pkg::pixel_t'(lcg_next());

		repeat (16) @(posedge i_clk);
		i_rst_n <= 1'b1;

		start_test("load_display");
		@(negedge i_clk);
		@(negedge i_clk);
		if (o_op_ready !== 1'b1) begin
			$display("o_op_ready did not rise on the first cycle after reset");
			errors++;
		end
		load_image();
		run_op(img_pkg::DISPLAY);
		report_test();

		start_test("moves_clamped");
		run_op(img_pkg::LEFT);
		run_op(img_pkg::UP);
		run_op(img_pkg::DISPLAY);
		repeat_op(img_pkg::RIGHT, 7);
		repeat_op(img_pkg::DOWN, 7);
		run_op(img_pkg::DISPLAY);
		repeat_op(img_pkg::LEFT, 2);
		repeat_op(img_pkg::UP, 3);
		run_op(img_pkg::DISPLAY);
		report_test();

		start_test("depth_clamped");
		repeat_op(img_pkg::REDUCE_DEPTH, 3);
		run_op(img_pkg::DISPLAY);
		repeat_op(img_pkg::INCREASE_DEPTH, 3);
		run_op(img_pkg::DISPLAY);
		run_op(img_pkg::REDUCE_DEPTH);
		run_op(img_pkg::DISPLAY);
		run_op(img_pkg::INCREASE_DEPTH);
		report_test();

		start_test("conv_corners");
		repeat_op(img_pkg::LEFT, 6);
		repeat_op(img_pkg::UP, 6);
		run_op(img_pkg::CONV);
		repeat_op(img_pkg::RIGHT, 6);
		run_op(img_pkg::CONV);
		repeat_op(img_pkg::DOWN, 6);
		run_op(img_pkg::CONV);
		repeat_op(img_pkg::LEFT, 3);
		repeat_op(img_pkg::UP, 3);
		run_op(img_pkg::CONV);
		run_op(img_pkg::REDUCE_DEPTH);
		run_op(img_pkg::CONV);
		report_test();

		start_test("quiet_ops");
		run_op(img_pkg::RIGHT);
		run_op(img_pkg::DOWN);
		run_op(img_pkg::INCREASE_DEPTH);
		run_op(img_pkg::LEFT);
		run_op(img_pkg::UP);
		run_op(img_pkg::REDUCE_DEPTH);
		report_test();

		start_test("random_mix");
		run_random_mix(N_RANDOM);
		report_test();

		$display("tests run %0d, bad %0d, checks %0d, errors %0d",
			tests_run, tests_bad, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: sim.f
logic/img_pkg.sv
logic/pixel_mem.sv
logic/img_ctrl.sv
logic/window_scan.sv
logic/filter_unit.sv
logic/img_core.sv
sim/img_core_asserts.sv
sim/tb_img_core.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_img_core -f sim.f -o tb_img_core

result=$(./obj_dir/tb_img_core 2>&1 || true)
echo "$result"

if echo "$result" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1
